// ==== hdmi_pix_proc.f ====
src/vid_pkg.sv
src/vid_ctrl_regs.sv
src/pix_gray.sv
src/pix_brightness.sv
src/tx_out_stage.sv
src/hdmi_pix_proc_top.sv
verification/tb_clk_gen.sv
verification/tb_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the hdmi pixel path testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_top \
    -f hdmi_pix_proc.f -Mdir obj_dir -o tb_top_sim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/tb_top_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# pass only if the testbench printed its pass line
if grep -q "^TEST OK$" "$LOG"; then
    exit 0
fi
exit 1

// ==== src/hdmi_pix_proc_top.sv ====
//**************************************************************************
// hdmi pixel processing top
// APB control block plus gray, brightness and output stages, 3 cycles
//**************************************************************************
`timescale 1ns/1ps
`default_nettype none

module hdmi_pix_proc_top
    import vid_pkg::*;
#(
    parameter int FRAME_CNT_W = 16
)(
    input  wire logic       hdmi_rx_pix_clk,
    input  wire logic       hdmi_rst_n,
    // apb
    input  wire logic       i_psel,
    input  wire logic       i_penable,
    input  wire logic       i_pwrite,
    input  wire apb_addr_t  i_paddr,
    input  wire apb_data_t  i_pwdata,
    output apb_data_t       o_prdata,
    // video in
    input  wire logic       i_rx_vs,
    input  wire logic       i_rx_hs,
    input  wire logic       i_rx_de,
    input  wire pix_t       i_rx_data,
    // video out
    output logic            o_tx_vs,
    output logic            o_tx_hs,
    output logic            o_tx_de,
    output pix_t            o_tx_data
);

    logic       out_en;                         // active settings
    logic       gray_en;
    bright_t    bright;

    logic       gray_vs;
    logic       gray_hs;
    logic       gray_de;
    pix_t       gray_data;

    logic       brt_vs;
    logic       brt_hs;
    logic       brt_de;
    pix_t       brt_data;

    vid_ctrl_regs #(
        .FRAME_CNT_W        (FRAME_CNT_W)
    ) u_vid_ctrl_regs (
        .hdmi_rx_pix_clk    (hdmi_rx_pix_clk),
        .hdmi_rst_n         (hdmi_rst_n),
        .i_psel             (i_psel),
        .i_penable          (i_penable),
        .i_pwrite           (i_pwrite),
        .i_paddr            (i_paddr),
        .i_pwdata           (i_pwdata),
        .o_prdata           (o_prdata),
        .i_rx_vs            (i_rx_vs),
        .o_out_en           (out_en),
        .o_gray_en          (gray_en),
        .o_bright           (bright)
    );

    pix_gray u_pix_gray (
        .hdmi_rx_pix_clk    (hdmi_rx_pix_clk),
        .hdmi_rst_n         (hdmi_rst_n),
        .i_vs               (i_rx_vs),
        .i_hs               (i_rx_hs),
        .i_de               (i_rx_de),
        .i_data             (i_rx_data),
        .i_gray_en          (gray_en),
        .o_vs               (gray_vs),
        .o_hs               (gray_hs),
        .o_de               (gray_de),
        .o_data             (gray_data)
    );

    pix_brightness u_pix_brightness (
        .hdmi_rx_pix_clk    (hdmi_rx_pix_clk),
        .hdmi_rst_n         (hdmi_rst_n),
        .i_vs               (gray_vs),
        .i_hs               (gray_hs),
        .i_de               (gray_de),
        .i_data             (gray_data),
        .i_bright           (bright),
        .o_vs               (brt_vs),
        .o_hs               (brt_hs),
        .o_de               (brt_de),
        .o_data             (brt_data)
    );

    tx_out_stage u_tx_out_stage (
        .hdmi_rx_pix_clk    (hdmi_rx_pix_clk),
        .hdmi_rst_n         (hdmi_rst_n),
        .i_vs               (brt_vs),
        .i_hs               (brt_hs),
        .i_de               (brt_de),
        .i_data             (brt_data),
        .i_out_en           (out_en),
        .o_vs               (o_tx_vs),
        .o_hs               (o_tx_hs),
        .o_de               (o_tx_de),
        .o_data             (o_tx_data)
    );

endmodule

`default_nettype wire

// ==== src/pix_brightness.sv ====
//**************************************************************************
// brightness stage
// adds a signed offset to each channel, clamps to 0..255, one cycle
//**************************************************************************
`timescale 1ns/1ps
`default_nettype none

module pix_brightness
    import vid_pkg::*;
(
    input  wire logic       hdmi_rx_pix_clk,
    input  wire logic       hdmi_rst_n,
    input  wire logic       i_vs,
    input  wire logic       i_hs,
    input  wire logic       i_de,
    input  wire pix_t       i_data,
    input  wire bright_t    i_bright,
    output logic            o_vs,
    output logic            o_hs,
    output logic            o_de,
    output pix_t            o_data
);

    // 10 bit sum covers -256..510
    function automatic chan_t add_clamp(chan_t c, bright_t b);
        logic [9:0] sum;
        sum = {2'b00, c} + {b[8], b};
        if (sum[9])
            return 8'd0;                        // went negative
        else if (sum[8])
            return 8'd255;                      // above 255
        else
            return sum[7:0];
    endfunction

    always_ff @(posedge hdmi_rx_pix_clk or negedge hdmi_rst_n)
    begin
        if (!hdmi_rst_n)
        begin
            o_vs <= 1'b0;
            o_hs <= 1'b0;
            o_de <= 1'b0;
        end
        else
        begin
            o_vs <= i_vs;
            o_hs <= i_hs;
            o_de <= i_de;
        end
    end

    always_ff @(posedge hdmi_rx_pix_clk)
    begin
        o_data <= {add_clamp(i_data[23:16], i_bright),
                   add_clamp(i_data[15:8],  i_bright),
                   add_clamp(i_data[7:0],   i_bright)};
    end

    // active pixel with no offset comes out unchanged, de one cycle behind
    a_de_follows: assert property (@(posedge hdmi_rx_pix_clk) disable iff (!hdmi_rst_n)
        i_de && (i_bright == '0) |=> o_de && (o_data == $past(i_data)));

endmodule

`default_nettype wire

// ==== src/pix_gray.sv ====
//**************************************************************************
// grayscale stage
// optional rgb to luma, luma copied into all three channels, one cycle
//**************************************************************************
`timescale 1ns/1ps
`default_nettype none

module pix_gray
    import vid_pkg::*;
(
    input  wire logic   hdmi_rx_pix_clk,
    input  wire logic   hdmi_rst_n,
    input  wire logic   i_vs,
    input  wire logic   i_hs,
    input  wire logic   i_de,
    input  wire pix_t   i_data,
    input  wire logic   i_gray_en,
    output logic        o_vs,
    output logic        o_hs,
    output logic        o_de,
    output pix_t        o_data
);

    logic [15:0]    luma_sum;                   // max 255 * 256
    chan_t          luma;

    assign luma_sum = 16'(LUMA_WR) * 16'(i_data[23:16])
                    + 16'(LUMA_WG) * 16'(i_data[15:8])
                    + 16'(LUMA_WB) * 16'(i_data[7:0]);
    assign luma     = luma_sum[15:8];

    // strobes
    always_ff @(posedge hdmi_rx_pix_clk or negedge hdmi_rst_n)
    begin
        if (!hdmi_rst_n)
        begin
            o_vs <= 1'b0;
            o_hs <= 1'b0;
            o_de <= 1'b0;
        end
        else
        begin
            o_vs <= i_vs;
            o_hs <= i_hs;
            o_de <= i_de;
        end
    end

    always_ff @(posedge hdmi_rx_pix_clk)
    begin
        o_data <= i_gray_en ? {luma, luma, luma} : i_data;     // pass through when off
    end

endmodule

`default_nettype wire

// ==== src/tx_out_stage.sv ====
//**************************************************************************
// hdmi output register
// drives the tx pins, held at zero while output is disabled
//**************************************************************************
`timescale 1ns/1ps
`default_nettype none

module tx_out_stage
    import vid_pkg::*;
(
    input  wire logic   hdmi_rx_pix_clk,
    input  wire logic   hdmi_rst_n,
    input  wire logic   i_vs,
    input  wire logic   i_hs,
    input  wire logic   i_de,
    input  wire pix_t   i_data,
    input  wire logic   i_out_en,
    output logic        o_vs,
    output logic        o_hs,
    output logic        o_de,
    output pix_t        o_data
);

    always_ff @(posedge hdmi_rx_pix_clk or negedge hdmi_rst_n)
    begin
        if (!hdmi_rst_n)
        begin
            o_vs   <= 1'b0;
            o_hs   <= 1'b0;
            o_de   <= 1'b0;
            o_data <= '0;
        end
        else if (!i_out_en)
        begin
            o_vs   <= 1'b0;                     // blank pins
            o_hs   <= 1'b0;
            o_de   <= 1'b0;
            o_data <= '0;
        end
        else
        begin
            o_vs   <= i_vs;
            o_hs   <= i_hs;
            o_de   <= i_de;
            o_data <= i_data;
        end
    end

endmodule

`default_nettype wire

// ==== src/vid_ctrl_regs.sv ====
//**************************************************************************
// video control registers
// APB programmed settings, copied to the active set on input vs rise,
// plus a frame counter
//**************************************************************************
`timescale 1ns/1ps
`default_nettype none

module vid_ctrl_regs
    import vid_pkg::*;
#(
    parameter int FRAME_CNT_W = 16
)(
    input  wire logic       hdmi_rx_pix_clk,
    input  wire logic       hdmi_rst_n,
    input  wire logic       i_psel,
    input  wire logic       i_penable,
    input  wire logic       i_pwrite,
    input  wire apb_addr_t  i_paddr,
    input  wire apb_data_t  i_pwdata,
    output apb_data_t       o_prdata,
    input  wire logic       i_rx_vs,
    output logic            o_out_en,
    output logic            o_gray_en,
    output bright_t         o_bright
);

    logic                   prog_out_en;    // programmed, not yet active
    logic                   prog_gray_en;
    bright_t                prog_bright;
    logic                   vs_d1;
    logic                   vs_d2;
    logic                   vs_rise;
    logic                   apb_wr;
    logic [FRAME_CNT_W-1:0] frame_cnt;

    assign apb_wr  = i_psel && i_penable && i_pwrite;  // end of access phase
    assign vs_rise = vs_d1 && !vs_d2;

    //**********************************************************************
    // apb write decode
    //**********************************************************************
    always_ff @(posedge hdmi_rx_pix_clk or negedge hdmi_rst_n)
    begin
        if (!hdmi_rst_n)
        begin
            prog_out_en  <= 1'b0;
            prog_gray_en <= 1'b0;
            prog_bright  <= '0;
        end
        else if (apb_wr)
        begin
            case (i_paddr)
                REG_CTRL:
                begin
                    prog_out_en  <= i_pwdata[0];
                    prog_gray_en <= i_pwdata[1];
                end
                REG_BRIGHT: prog_bright <= bright_t'(i_pwdata[8:0]);
                default:    ;                               // frames is read only
            endcase
        end
    end

    // read data valid in the access phase
    always_comb
    begin
        case (i_paddr)
            REG_CTRL:   o_prdata = {30'd0, prog_gray_en, prog_out_en};
            REG_BRIGHT: o_prdata = {23'd0, prog_bright};
            REG_FRAMES: o_prdata = apb_data_t'(frame_cnt);
            default:    o_prdata = '0;
        endcase
    end

    //**********************************************************************
    // frame boundary update
    //**********************************************************************
    always_ff @(posedge hdmi_rx_pix_clk or negedge hdmi_rst_n)
    begin
        if (!hdmi_rst_n)
        begin
            vs_d1     <= 1'b0;
            vs_d2     <= 1'b0;
            o_out_en  <= 1'b0;
            o_gray_en <= 1'b0;
            o_bright  <= '0;
            frame_cnt <= '0;
        end
        else
        begin
            vs_d1 <= i_rx_vs;
            vs_d2 <= vs_d1;
            if (vs_rise)
            begin
                o_out_en  <= prog_out_en;
                o_gray_en <= prog_gray_en;
                o_bright  <= prog_bright;
                frame_cnt <= frame_cnt + 1'b1;      // wraps at FRAME_CNT_W
            end
        end
    end

    // access phase must follow a setup phase
    a_apb_setup_first: assert property (@(posedge hdmi_rx_pix_clk) disable iff (!hdmi_rst_n)
        i_penable |-> $past(i_psel));

endmodule

`default_nettype wire

// ==== src/vid_pkg.sv ====
//**************************************************************************
// video pixel path shared types
// pixel, channel and APB types, register map and luma weights
//**************************************************************************
`default_nettype none

package vid_pkg;

    typedef logic [7:0]         chan_t;         // one colour channel
    typedef logic [23:0]        pix_t;          // rgb888, red in top byte
    typedef logic signed [8:0]  bright_t;       // signed brightness offset
    typedef logic [3:0]         apb_addr_t;     // apb byte address
    typedef logic [31:0]        apb_data_t;     // apb data word

    // register map
    localparam apb_addr_t REG_CTRL   = 4'h0;    // out_en, gray_en
    localparam apb_addr_t REG_BRIGHT = 4'h4;    // signed offset
    localparam apb_addr_t REG_FRAMES = 4'h8;    // vs rising edges, read only

    // luma weights, sum is 256 so the result is >> 8
    localparam logic [7:0] LUMA_WR = 8'd77;
    localparam logic [7:0] LUMA_WG = 8'd150;
    localparam logic [7:0] LUMA_WB = 8'd29;

endpackage

`default_nettype wire

// ==== verification/tb_clk_gen.sv ====
//**************************************************************************
// testbench clock and reset
// 10 ns pixel clock, active low reset held for the first 3 cycles
//**************************************************************************
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 3
)(
    output logic    hdmi_rx_pix_clk,
    output logic    hdmi_rst_n
);

    initial
    begin
        hdmi_rx_pix_clk = 1'b0;
        forever #(PERIOD_NS / 2) hdmi_rx_pix_clk = ~hdmi_rx_pix_clk;
    end

    initial
    begin
        hdmi_rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge hdmi_rx_pix_clk);
        hdmi_rst_n <= 1'b1;                     // release on a rising edge
    end

endmodule

`default_nettype wire

// ==== verification/tb_top.sv ====
//**************************************************************************
// hdmi pixel path testbench
// random frames and APB settings, reference model, 3 cycle output checks
//**************************************************************************
`timescale 1ns/1ps
`default_nettype none

module tb_top
    import vid_pkg::*;
();

    localparam int FRAME_CNT_W  = 16;
    localparam int NUM_FRAMES   = 12;
    localparam int LINES        = 8;
    localparam int PIXELS       = 16;
    localparam int HS_CYCLES    = 4;
    localparam int BPORCH       = 2;
    localparam int FPORCH       = 2;
    localparam int VS_CYCLES    = 13;           // apb traffic runs here
    localparam int VBP_CYCLES   = 2;
    localparam int LINE_CYCLES  = HS_CYCLES + BPORCH + PIXELS + FPORCH;
    localparam int FRAME_CYCLES = VS_CYCLES + VBP_CYCLES + LINES * LINE_CYCLES;
    localparam int MAX_CYCLES   = 2 * NUM_FRAMES * FRAME_CYCLES;

    logic           hdmi_rx_pix_clk;
    logic           hdmi_rst_n;
    logic           psel;
    logic           penable;
    logic           pwrite;
    apb_addr_t      paddr;
    apb_data_t      pwdata;
    apb_data_t      prdata;
    logic           rx_vs;
    logic           rx_hs;
    logic           rx_de;
    pix_t           rx_data;
    logic           tx_vs;
    logic           tx_hs;
    logic           tx_de;
    pix_t           tx_data;

    // apb values for the next driven cycle
    logic           nxt_psel;
    logic           nxt_penable;
    logic           nxt_pwrite;
    apb_addr_t      nxt_paddr;
    apb_data_t      nxt_pwdata;

    // model state
    logic           m_out_en;                   // programmed
    logic           m_gray_en;
    bright_t        m_bright;
    logic           f_out_en;                   // governs the current frame
    logic           f_gray_en;
    bright_t        f_bright;
    logic           last_vs;
    int             frames_seen;
    logic [27:0]    exp_q[$];                   // {chk_data, vs, hs, de, data}
    logic [27:0]    exp_now;
    int             video_errors;
    int             apb_errors;
    int             cycles = 0;
    integer         seed;

    tb_clk_gen u_clk_gen (
        .hdmi_rx_pix_clk    (hdmi_rx_pix_clk),
        .hdmi_rst_n         (hdmi_rst_n)
    );

    hdmi_pix_proc_top #(
        .FRAME_CNT_W        (FRAME_CNT_W)
    ) dut (
        .hdmi_rx_pix_clk    (hdmi_rx_pix_clk),
        .hdmi_rst_n         (hdmi_rst_n),
        .i_psel             (psel),
        .i_penable          (penable),
        .i_pwrite           (pwrite),
        .i_paddr            (paddr),
        .i_pwdata           (pwdata),
        .o_prdata           (prdata),
        .i_rx_vs            (rx_vs),
        .i_rx_hs            (rx_hs),
        .i_rx_de            (rx_de),
        .i_rx_data          (rx_data),
        .o_tx_vs            (tx_vs),
        .o_tx_hs            (tx_hs),
        .o_tx_de            (tx_de),
        .o_tx_data          (tx_data)
    );

    //**********************************************************************
    // reference model
    //**********************************************************************
    function automatic chan_t luma_of(pix_t p);
        int sum;
        sum = int'(LUMA_WR) * int'(p[23:16]) + int'(LUMA_WG) * int'(p[15:8])
            + int'(LUMA_WB) * int'(p[7:0]);
        return chan_t'(sum / 256);
    endfunction

    function automatic chan_t offset_clamp(chan_t c, bright_t off);
        int v;
        v = int'(c) + int'(off);                // off sign extends
        if (v < 0)
            return 8'd0;
        else if (v > 255)
            return 8'd255;
        else
            return chan_t'(v);
    endfunction

    function automatic logic [27:0] expected_out(logic vs, logic hs, logic de, pix_t data);
        chan_t r;
        chan_t g;
        chan_t b;
        if (!f_out_en)
            return {1'b1, 27'd0};               // pins held low
        if (f_gray_en)
        begin
            r = luma_of(data);
            g = r;
            b = r;
        end
        else
        begin
            r = data[23:16];
            g = data[15:8];
            b = data[7:0];
        end
        return {de, vs, hs, de, offset_clamp(r, f_bright), offset_clamp(g, f_bright),
                offset_clamp(b, f_bright)};
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp, inout int count);
        assert (got === exp)
        else
        begin
            count++;
            $display("error: time %0t %s expected %0h got %0h", $time, name, exp, got);
        end
    endtask

    //**********************************************************************
    // stimulus
    //**********************************************************************
    task automatic video_cycle(input logic vs, input logic hs, input logic de, input pix_t data);
        @(posedge hdmi_rx_pix_clk);
        rx_vs   <= vs;
        rx_hs   <= hs;
        rx_de   <= de;
        rx_data <= data;
        psel    <= nxt_psel;
        penable <= nxt_penable;
        pwrite  <= nxt_pwrite;
        paddr   <= nxt_paddr;
        pwdata  <= nxt_pwdata;
        if (vs && !last_vs)
        begin
            f_out_en  = m_out_en;               // frame boundary
            f_gray_en = m_gray_en;
            f_bright  = m_bright;
            frames_seen++;
        end
        last_vs = vs;
        exp_q.push_back(expected_out(vs, hs, de, data));
    endtask

    task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
        nxt_psel    = 1'b1;
        nxt_penable = 1'b0;
        nxt_pwrite  = 1'b1;
        nxt_paddr   = addr;
        nxt_pwdata  = data;
        video_cycle(1'b1, 1'b0, 1'b0, '0);      // setup
        nxt_penable = 1'b1;
        video_cycle(1'b1, 1'b0, 1'b0, '0);      // access
        nxt_psel    = 1'b0;
        nxt_penable = 1'b0;
        nxt_pwrite  = 1'b0;
        if (addr == REG_CTRL)
        begin
            m_out_en  = data[0];
            m_gray_en = data[1];
        end
        else if (addr == REG_BRIGHT)
            m_bright = bright_t'(data[8:0]);
    endtask

    task automatic apb_read(input apb_addr_t addr, input apb_data_t exp);
        nxt_psel    = 1'b1;
        nxt_penable = 1'b0;
        nxt_pwrite  = 1'b0;
        nxt_paddr   = addr;
        video_cycle(1'b1, 1'b0, 1'b0, '0);
        nxt_penable = 1'b1;
        video_cycle(1'b1, 1'b0, 1'b0, '0);
        @(negedge hdmi_rx_pix_clk);             // access phase data
        compare_value("o_prdata", prdata, exp, apb_errors);
        nxt_psel    = 1'b0;
        nxt_penable = 1'b0;
    endtask

    // fixed settings first so every behaviour is covered, then random
    task automatic choose_settings(input int idx, output apb_data_t ctrl, output apb_data_t bright);
        case (idx)
            0:
            begin
                ctrl   = 32'd1;                 // pass through
                bright = 32'd0;
            end
            1:
            begin
                ctrl   = 32'd3;                 // gray only
                bright = 32'd0;
            end
            2:
            begin
                ctrl   = 32'd1;                 // +128
                bright = 32'h080;
            end
            3:
            begin
                ctrl   = 32'd3;                 // -128
                bright = 32'h180;
            end
            4:
            begin
                ctrl   = 32'd0;                 // output off
                bright = 32'h040;
            end
            default:
            begin
                ctrl   = $random(seed);
                bright = $random(seed);         // upper bits ignored by DUT
            end
        endcase
    endtask

    task automatic run_frame(input int idx);
        apb_data_t ctrl;
        apb_data_t bright;
        apb_data_t frames_exp;
        repeat (2) video_cycle(1'b1, 1'b0, 1'b0, '0);
        choose_settings(idx, ctrl, bright);
        apb_write(REG_CTRL, ctrl);
        apb_write(REG_BRIGHT, bright);
        apb_read(REG_CTRL, ctrl & 32'h3);
        apb_read(REG_BRIGHT, bright & 32'h1ff);
        frames_exp = apb_data_t'(frames_seen) & ((32'd1 << FRAME_CNT_W) - 32'd1);
        apb_read(REG_FRAMES, frames_exp);
        video_cycle(1'b1, 1'b0, 1'b0, '0);
        repeat (VBP_CYCLES) video_cycle(1'b0, 1'b0, 1'b0, '0);
        for (int ln = 0; ln < LINES; ln++)
        begin
            repeat (HS_CYCLES) video_cycle(1'b0, 1'b1, 1'b0, '0);
            repeat (BPORCH) video_cycle(1'b0, 1'b0, 1'b0, '0);
            for (int px = 0; px < PIXELS; px++)
                video_cycle(1'b0, 1'b0, 1'b1, pix_t'($random(seed)));
            repeat (FPORCH) video_cycle(1'b0, 1'b0, 1'b0, '0);
        end
    endtask

    //**********************************************************************
    // output checks, taken at the falling edge
    //**********************************************************************
    always @(negedge hdmi_rx_pix_clk)
    begin
        if (!hdmi_rst_n)
        begin
            compare_value("o_tx_vs", {31'd0, tx_vs}, 32'd0, video_errors);
            compare_value("o_tx_hs", {31'd0, tx_hs}, 32'd0, video_errors);
            compare_value("o_tx_de", {31'd0, tx_de}, 32'd0, video_errors);
            compare_value("o_tx_data", {8'd0, tx_data}, 32'd0, video_errors);
        end
        else if (exp_q.size() > 3)
        begin
            exp_now = exp_q.pop_front();        // input from 3 cycles back
            compare_value("o_tx_vs", {31'd0, tx_vs}, {31'd0, exp_now[26]}, video_errors);
            compare_value("o_tx_hs", {31'd0, tx_hs}, {31'd0, exp_now[25]}, video_errors);
            compare_value("o_tx_de", {31'd0, tx_de}, {31'd0, exp_now[24]}, video_errors);
            if (exp_now[27])
                compare_value("o_tx_data", {8'd0, tx_data}, {8'd0, exp_now[23:0]},
                              video_errors);
        end
    end

    always @(posedge hdmi_rx_pix_clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES)
        begin
            $display("timeout: run did not complete within %0d cycles", MAX_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial
    begin
        seed         = 91696;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = '0;
        pwdata       = '0;
        rx_vs        = 1'b0;
        rx_hs        = 1'b0;
        rx_de        = 1'b0;
        rx_data      = '0;
        nxt_psel     = 1'b0;
        nxt_penable  = 1'b0;
        nxt_pwrite   = 1'b0;
        nxt_paddr    = '0;
        nxt_pwdata   = '0;
        m_out_en     = 1'b0;                    // reset values
        m_gray_en    = 1'b0;
        m_bright     = '0;
        f_out_en     = 1'b0;
        f_gray_en    = 1'b0;
        f_bright     = '0;
        last_vs      = 1'b0;
        frames_seen  = 0;
        video_errors = 0;
        apb_errors   = 0;

        wait (hdmi_rst_n === 1'b1);
        repeat (4) video_cycle(1'b0, 1'b0, 1'b0, '0);
        for (int i = 0; i < NUM_FRAMES; i++)
            run_frame(i);
        repeat (4) video_cycle(1'b0, 1'b0, 1'b0, '0);   // drain pipeline
        @(posedge hdmi_rx_pix_clk);             // last falling edge check done

        $display("errors: video %0d, apb %0d", video_errors, apb_errors);
        if (video_errors == 0 && apb_errors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire
